//--- src/scope_pkg.sv
package scope_pkg;

    ////////////////////////////////////////
    // Sample and setting widths
    ////////////////////////////////////////

    localparam int SAMPLE_W = 12;

    // Unsigned ADC level in counts
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Right shift applied per volts-per-division step
    typedef logic [1:0] scale_t;

    // Trace buffer word address
    typedef logic [7:0] addr_t;

    // Full scale count, used for saturating the upper trigger bound
    localparam sample_t SAMPLE_MAX = '1;

    ////////////////////////////////////////
    // Trace buffer
    ////////////////////////////////////////

    localparam int    BUF_DEPTH = 256;
    localparam addr_t LAST_ADDR = addr_t'(BUF_DEPTH - 1);

    // Sample travelling through the pipeline, trig marks word 0
    typedef struct packed {
        sample_t data;
        logic    trig;
    } tagged_sample_t;

    // Write request from the capture controller
    typedef struct packed {
        addr_t   addr;
        sample_t data;
    } mem_req_t;

    typedef enum logic [1:0] {IDLE, ARMED, CAPTURE, DONE} cap_state_t;

endpackage

//--- src/sample_scaler.sv
`timescale 1ns/1ps

module sample_scaler (
    input  logic                      clk,
    input  logic                      rst,
    input  scope_pkg::scale_t         scale,
    input  logic                      in_valid,
    input  scope_pkg::sample_t        in_data,
    output logic                      in_ready,
    output logic                      out_valid,
    output scope_pkg::tagged_sample_t out_data,
    input  logic                      out_ready
);

    // Ready stays low until the first edge after reset
    logic ready_en;
    logic take;

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = ready_en && (!out_valid || out_ready);
    assign take     = in_valid && in_ready;

    ////////////////////////////////////////
    // Control flops
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ready_en  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Scaled sample, trigger tag is added downstream
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= '{data: in_data >> scale, trig: 1'b0};
        end
    end

    // Stalled output must not change
    stall_hold: assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- src/trigger_detect.sv
`timescale 1ns/1ps

module trigger_detect #(
    parameter scope_pkg::sample_t HYST = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  scope_pkg::sample_t        level,
    input  logic                      falling,
    input  logic                      armed,
    input  logic                      arm,
    input  logic                      in_valid,
    input  scope_pkg::tagged_sample_t in_data,
    output logic                      in_ready,
    output logic                      out_valid,
    output scope_pkg::tagged_sample_t out_data,
    input  logic                      out_ready
);
    import scope_pkg::*;

    logic           primed;
    logic           take;
    logic [12:0]    hi_sum;
    sample_t        lo_bound;
    sample_t        hi_bound;
    logic           at_level;
    logic           far_side;
    logic           fire;

    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    ////////////////////////////////////////
    // Hysteresis bounds
    ////////////////////////////////////////
    // Both bounds clip at the ends of the ADC range
    assign hi_sum   = {1'b0, level} + {1'b0, HYST};
    assign lo_bound = (level > HYST) ? level - HYST : '0;
    assign hi_bound = (hi_sum > SAMPLE_MAX) ? SAMPLE_MAX : hi_sum[11:0];

    // Falling mode mirrors rising mode
    assign at_level = falling ? (in_data.data <= level) : (in_data.data >= level);
    assign far_side = falling ? (in_data.data > hi_bound) : (in_data.data < lo_bound);
    assign fire     = primed && at_level;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            primed    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            // Arm wipes old history
            if (arm) begin
                primed <= 1'b0;
            end else if (take) begin
                if (fire)
                    primed <= 1'b0;
                else if (far_side)
                    primed <= 1'b1;
            end
            if (take)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

    // Tag only fires seen while the controller waits
    always_ff @(posedge clk) begin
        if (take)
            out_data <= '{data: in_data.data, trig: fire && armed};
    end

endmodule

//--- src/capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      arm,
    input  logic                      in_valid,
    input  scope_pkg::tagged_sample_t in_data,
    output logic                      in_ready,
    output logic                      armed,
    output logic                      wr_valid,
    output scope_pkg::mem_req_t       wr_req,
    input  logic                      wr_ready,
    output logic                      capture_done
);
    import scope_pkg::*;

    cap_state_t state;
    addr_t      wr_addr;
    logic       wr_take;

    assign armed = (state == ARMED);

    // Samples go straight through as writes
    assign wr_valid = (state == CAPTURE) && in_valid;
    assign wr_req   = '{addr: wr_addr, data: in_data.data};
    assign wr_take  = wr_valid && wr_ready;

    ////////////////////////////////////////
    // Upstream ready
    ////////////////////////////////////////
    always_comb begin
        case (state)
            // Trigger sample waits until CAPTURE can present it
            ARMED:   in_ready = !(in_valid && in_data.trig);
            // Buffer stalls propagate back to the ADC
            CAPTURE: in_ready = wr_ready;
            default: in_ready = 1'b1;
        endcase
    end

    ////////////////////////////////////////
    // Capture FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state        <= IDLE;
            wr_addr      <= '0;
            capture_done <= 1'b0;
        end else if (arm) begin
            state        <= ARMED;
            capture_done <= 1'b0;
        end else begin
            case (state)
                ARMED: begin
                    if (in_valid && in_data.trig) begin
                        state   <= CAPTURE;
                        wr_addr <= '0;
                    end
                end
                CAPTURE: begin
                    if (wr_take) begin
                        wr_addr <= addr_t'(wr_addr + 1'b1);
                        // Last word written
                        if (wr_addr == LAST_ADDR) begin
                            state        <= DONE;
                            capture_done <= 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Completed trace stays untouched until the next arm
    wr_only_capture: assert property (@(posedge clk) disable iff (!rst)
        wr_valid |-> !capture_done);

    // Lost arbitration keeps the same request
    wr_hold: assert property (@(posedge clk) disable iff (!rst)
        wr_valid && !wr_ready && !arm |=> wr_valid && $stable(wr_req));

endmodule

//--- src/trace_buffer.sv
`timescale 1ns/1ps

module trace_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_valid,
    input  scope_pkg::mem_req_t wr_req,
    output logic                wr_ready,
    input  logic                rd_valid,
    input  scope_pkg::addr_t    rd_addr,
    output logic                rd_ready,
    output scope_pkg::sample_t  rd_data,
    output logic                rd_data_valid
);
    import scope_pkg::*;

    sample_t mem [BUF_DEPTH];

    // High when the read port won the last granted cycle
    logic last_rd;
    // Grants held off until the first edge after reset
    logic gnt_en;
    logic wr_gnt;
    logic rd_gnt;

    ////////////////////////////////////////
    // Round-robin arbiter
    ////////////////////////////////////////
    // Writer wins alone or when the reader went last
    assign wr_gnt = gnt_en && wr_valid && (!rd_valid || last_rd);
    // Reader wins alone or when the writer went last
    assign rd_gnt = gnt_en && rd_valid && (!wr_valid || !last_rd);

    assign wr_ready = wr_gnt;
    assign rd_ready = rd_gnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            // Writer goes first after reset
            last_rd       <= 1'b1;
            gnt_en        <= 1'b0;
            rd_data_valid <= 1'b0;
        end else begin
            gnt_en <= 1'b1;
            if (wr_gnt)
                last_rd <= 1'b0;
            else if (rd_gnt)
                last_rd <= 1'b1;
            // Data follows the read transfer by one cycle
            rd_data_valid <= rd_gnt;
        end
    end

    ////////////////////////////////////////
    // Sample memory
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_gnt)
            mem[wr_req.addr] <= wr_req.data;
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (rd_gnt)
            rd_data <= mem[rd_addr];
    end

    one_grant: assert property (@(posedge clk) disable iff (!rst)
        !(wr_ready && rd_ready));

    // Under contention the reader follows a writer grant
    fair_turn: assert property (@(posedge clk) disable iff (!rst)
        wr_valid && rd_valid && wr_ready |=> !(wr_valid && rd_valid) || rd_ready);

endmodule

//--- src/scope_capture.sv
`timescale 1ns/1ps

module scope_capture #(
    parameter scope_pkg::sample_t HYST = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  scope_pkg::scale_t  scale,
    input  scope_pkg::sample_t level,
    input  logic               falling,
    input  logic               arm,
    input  logic               sample_valid,
    input  scope_pkg::sample_t sample,
    output logic               sample_ready,
    input  logic               rd_valid,
    input  scope_pkg::addr_t   rd_addr,
    output logic               rd_ready,
    output scope_pkg::sample_t rd_data,
    output logic               rd_data_valid,
    output logic               capture_done
);
    import scope_pkg::*;

    // Scaler to detector
    logic           scl_valid;
    logic           scl_ready;
    tagged_sample_t scl_data;

    // Detector to controller
    logic           det_valid;
    logic           det_ready;
    tagged_sample_t det_data;

    // Controller to buffer
    logic           armed;
    logic           wr_valid;
    logic           wr_ready;
    mem_req_t       wr_req;

    ////////////////////////////////////////
    // Sample pipeline
    ////////////////////////////////////////
    sample_scaler u_scaler (
        .clk       (clk),
        .rst       (rst),
        .scale     (scale),
        .in_valid  (sample_valid),
        .in_data   (sample),
        .in_ready  (sample_ready),
        .out_valid (scl_valid),
        .out_data  (scl_data),
        .out_ready (scl_ready)
    );

    trigger_detect #(
        .HYST (HYST)
    ) u_trigger (
        .clk       (clk),
        .rst       (rst),
        .level     (level),
        .falling   (falling),
        .armed     (armed),
        .arm       (arm),
        .in_valid  (scl_valid),
        .in_data   (scl_data),
        .in_ready  (scl_ready),
        .out_valid (det_valid),
        .out_data  (det_data),
        .out_ready (det_ready)
    );

    ////////////////////////////////////////
    // Capture and storage
    ////////////////////////////////////////
    capture_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .arm          (arm),
        .in_valid     (det_valid),
        .in_data      (det_data),
        .in_ready     (det_ready),
        .armed        (armed),
        .wr_valid     (wr_valid),
        .wr_req       (wr_req),
        .wr_ready     (wr_ready),
        .capture_done (capture_done)
    );

    // Display side reads share the memory with the writer
    trace_buffer u_buffer (
        .clk           (clk),
        .rst           (rst),
        .wr_valid      (wr_valid),
        .wr_req        (wr_req),
        .wr_ready      (wr_ready),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .rd_ready      (rd_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

endmodule

//--- bench/scope_capture_tb.sv
`timescale 1ns/1ps

module scope_capture_tb;
    import scope_pkg::*;

    localparam sample_t HYST        = 12'd8;
    localparam int      WATCHDOG_NS = 6 * 2000 * 4 * 20;

    logic    clk;
    logic    rst;
    scale_t  scale;
    sample_t level;
    logic    falling;
    logic    arm;
    logic    sample_valid;
    sample_t sample;
    logic    sample_ready;
    logic    rd_valid;
    addr_t   rd_addr;
    logic    rd_ready;
    sample_t rd_data;
    logic    rd_data_valid;
    logic    capture_done;

    int      seed;
    int      errors;
    int      pass_cnt;
    int      fail_cnt;
    sample_t stim_q [$];
    sample_t exp_words [BUF_DEPTH];

    scope_capture #(.HYST(HYST)) uut (
        .clk           (clk),
        .rst           (rst),
        .scale         (scale),
        .level         (level),
        .falling       (falling),
        .arm           (arm),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .sample_ready  (sample_ready),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .rd_ready      (rd_ready),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .capture_done  (capture_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Hard stop on a hung run
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    // Scaled level trigger with hysteresis gives the trigger index or -1
    function automatic int build_expected(input sample_t raw[$], input int sc, input int lvl,
                                          input bit fall, output sample_t words[BUF_DEPTH]);
        int lo;
        int hi;
        int s;
        int first;
        int n;
        bit primed;
        lo = lvl - int'(HYST);
        if (lo < 0)
            lo = 0;
        hi = lvl + int'(HYST);
        if (hi > 4095)
            hi = 4095;
        primed = 1'b0;
        first  = -1;
        for (n = 0; n < raw.size(); n++) begin
            s = int'(raw[n]) >> sc;
            if (first < 0) begin
                if (primed && (fall ? (s <= lvl) : (s >= lvl)))
                    first = n;
                else if (fall ? (s > hi) : (s < lo))
                    primed = 1'b1;
            end
        end
        for (n = 0; n < BUF_DEPTH; n++) begin
            if (first >= 0 && first + n < raw.size())
                words[n] = sample_t'(int'(raw[first + n]) >> sc);
            else
                words[n] = '0;
        end
        return first;
    endfunction

    ////////////////////////////////////////
    // Stimulus builders
    ////////////////////////////////////////
    task automatic make_sawtooth(input int step, input int count);
        int n;
        stim_q.delete();
        for (n = 0; n < count; n++)
            stim_q.push_back(sample_t'((n * step) % 4096));
    endtask

    // Noise around the level, a high plateau, then a slow fall through the level
    task automatic make_noisy_fall();
        int n;
        int v;
        stim_q.delete();
        for (n = 0; n < 100; n++) begin
            v = 500 + ($random(seed) % 5);
            stim_q.push_back(sample_t'(v * 4 + ($random(seed) & 3)));
        end
        for (n = 0; n < 30; n++)
            stim_q.push_back(sample_t'(2600));
        for (n = 0; n < 350; n++) begin
            v = 650 - 3 * n;
            if (v < 0)
                v = 0;
            stim_q.push_back(sample_t'(v * 4 + (n & 3)));
        end
    endtask

    task automatic report_value(input string sig, input int exp, input int act);
        $display("FAILED at %0d ns: %s expected %0h got %0h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic finish_test(input string name, input int start_err);
        if (errors == start_err) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, errors - start_err);
        end
    endtask

    ////////////////////////////////////////
    // Sample stream and readback
    ////////////////////////////////////////
    // Random idle gaps between samples that are each held until taken
    task automatic stream_samples();
        int gap;
        int i;
        for (i = 0; i < stim_q.size(); i++) begin
            gap = $random(seed) & 3;
            repeat (gap) begin
                @(negedge clk);
                sample_valid = 1'b0;
            end
            @(negedge clk);
            sample_valid = 1'b1;
            sample       = stim_q[i];
            #1;
            while (!sample_ready) begin
                @(negedge clk);
                #1;
            end
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    // Reads every word and checks data timing and optionally the contents
    task automatic read_all(input bit compare);
        int addr;
        int pend;
        addr = 0;
        pend = -1;
        while (addr < BUF_DEPTH || pend >= 0) begin
            @(negedge clk);
            // Data valid only in the cycle after a transfer
            if (rd_data_valid !== (pend >= 0))
                report_value("rd_data_valid", int'(pend >= 0), int'(rd_data_valid));
            if (compare && pend >= 0 && rd_data !== exp_words[pend])
                report_value($sformatf("rd_data[%0d]", pend), int'(exp_words[pend]),
                             int'(rd_data));
            pend = -1;
            if (addr < BUF_DEPTH) begin
                rd_valid = 1'b1;
                rd_addr  = addr_t'(addr);
                #1;
                if (rd_ready) begin
                    pend = addr;
                    addr++;
                end
            end else begin
                rd_valid = 1'b0;
            end
        end
    endtask

    task automatic run_capture(input string name, input scale_t sc, input sample_t lvl,
                               input bit fall, input bit with_reads);
        int first;
        int start_err;
        int wait_cnt;
        int passes;
        start_err = errors;
        @(negedge clk);
        scale   = sc;
        level   = lvl;
        falling = fall;
        // Pipeline drains before arm
        repeat (4) @(negedge clk);
        arm = 1'b1;
        @(negedge clk);
        arm = 1'b0;
        if (capture_done !== 1'b0)
            report_value("capture_done", 0, int'(capture_done));
        first = build_expected(stim_q, int'(sc), int'(lvl), fall, exp_words);
        if (first < 0 || first + BUF_DEPTH > stim_q.size()) begin
            $display("FAILED at %0d ns: stimulus for %s has no full capture", $time, name);
            errors++;
        end
        if (with_reads) begin
            // Display reads compete with the writer
            fork
                stream_samples();
                begin
                    passes = 0;
                    while (!capture_done && passes < 8) begin
                        read_all(1'b0);
                        passes++;
                    end
                end
            join
        end else begin
            stream_samples();
        end
        wait_cnt = 0;
        while (!capture_done && wait_cnt < 200) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!capture_done) begin
            $display("FAILED at %0d ns: capture_done did not rise in %s", $time, name);
            errors++;
        end
        read_all(1'b1);
        finish_test(name, start_err);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        seed         = 32'ha12e_94c6;
        errors       = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        rst          = 1'b0;
        scale        = '0;
        level        = '0;
        falling      = 1'b0;
        arm          = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        // Read request held through reset must not be granted
        rd_valid     = 1'b1;
        rd_addr      = '0;

        // Outputs quiet in reset and ready one cycle after release
        repeat (16) @(negedge clk);
        if (capture_done !== 1'b0)
            report_value("capture_done", 0, int'(capture_done));
        if (sample_ready !== 1'b0)
            report_value("sample_ready", 0, int'(sample_ready));
        if (rd_ready !== 1'b0)
            report_value("rd_ready", 0, int'(rd_ready));
        if (rd_data_valid !== 1'b0)
            report_value("rd_data_valid", 0, int'(rd_data_valid));
        rst      = 1'b1;
        rd_valid = 1'b0;
        @(negedge clk);
        if (sample_ready !== 1'b1)
            report_value("sample_ready", 1, int'(sample_ready));
        finish_test("reset values", 0);

        make_sawtooth(37, 600);
        run_capture("rising trigger, scale 0", 2'd0, 12'd2000, 1'b0, 1'b0);
        make_noisy_fall();
        run_capture("falling trigger after noise, scale 2", 2'd2, 12'd500, 1'b1, 1'b0);
        make_sawtooth(29, 600);
        run_capture("reads during capture, scale 1", 2'd1, 12'd1000, 1'b0, 1'b1);
        make_sawtooth(13, 600);
        run_capture("re-arm with new level, scale 3", 2'd3, 12'd300, 1'b0, 1'b0);

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- scope_capture.f
src/scope_pkg.sv
src/sample_scaler.sv
src/trigger_detect.sv
src/capture_ctrl.sv
src/trace_buffer.sv
src/scope_capture.sv
bench/scope_capture_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the scope_capture testbench with Verilator, runs it and checks sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module scope_capture_tb \
    -f scope_capture.f -o scope_capture_sim \
    && ./obj_dir/scope_capture_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log

cat sim.log

grep -qF "*** TEST FAILED ***" sim.log && exit 1
grep -qF "*** TEST PASSED ***" sim.log || exit 1
exit 0
